//--- rtl/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// core-local timer window, 64 KiB
`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'h0000_ffff

// mtime word offsets inside the window
`define MTIME_LO_OFF 32'h0000_bff8
`define MTIME_HI_OFF 32'h0000_bffc

`endif

//--- rtl/bus_pkg.sv
`include "bus_cfg.svh"

package bus_pkg;

  typedef logic [`BUS_ADDR_W-1:0] addr_t;
  typedef logic [`BUS_DATA_W-1:0] data_t;
  typedef logic [`BUS_DATA_W/8-1:0] strb_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_FETCH_RD,
    ARB_LSU_RD,
    ARB_LSU_WR
  } arb_state_e;

  typedef enum logic [1:0] {
    ROUTE_NONE,
    ROUTE_EXT,
    ROUTE_CLINT_RD,
    ROUTE_CLINT_WR
  } route_e;

endpackage

//--- rtl/axi_lite_if.sv
interface axi_lite_if;
  import bus_pkg::*;

  logic      awvalid;
  logic      awready;
  addr_t     awaddr;
  logic      wvalid;
  logic      wready;
  data_t     wdata;
  strb_t     wstrb;
  logic      bvalid;
  logic      bready;
  axi_resp_e bresp;
  logic      arvalid;
  logic      arready;
  addr_t     araddr;
  logic      rvalid;
  logic      rready;
  data_t     rdata;
  axi_resp_e rresp;

  modport manager (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  // faces a read-only manager, so only ar and r
  modport fetch_manager (
    input  arvalid, araddr, rready,
    output arready, rvalid, rdata, rresp
  );

  modport subordinate (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

//--- rtl/bus_arbiter.sv
module bus_arbiter (
  input logic               clock,
  input logic               reset,
  axi_lite_if.fetch_manager fetch_bus,
  axi_lite_if.subordinate   lsu_bus,
  axi_lite_if.manager       out_bus
);
  import bus_pkg::*;

  arb_state_e state;
  arb_state_e state_next;
  logic       grant_fetch;
  logic       grant_lsu_rd;
  logic       grant_lsu_wr;
  logic       resp_done;

  assign grant_fetch  = (state == ARB_FETCH_RD);
  assign grant_lsu_rd = (state == ARB_LSU_RD);
  assign grant_lsu_wr = (state == ARB_LSU_WR);

  assign resp_done = (out_bus.rvalid && out_bus.rready) ||
                     (out_bus.bvalid && out_bus.bready);

  // load/store wins a tie
  always_comb begin
    state_next = state;
    case (state)
      ARB_IDLE: begin
        if (lsu_bus.awvalid && lsu_bus.wvalid) begin
          state_next = ARB_LSU_WR;
        end else if (lsu_bus.arvalid) begin
          state_next = ARB_LSU_RD;
        end else if (fetch_bus.arvalid) begin
          state_next = ARB_FETCH_RD;
        end
      end
      default: begin
        if (resp_done) begin
          state_next = ARB_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= ARB_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // request side
  assign out_bus.arvalid = (grant_fetch && fetch_bus.arvalid) ||
                           (grant_lsu_rd && lsu_bus.arvalid);
  assign out_bus.araddr  = grant_fetch ? fetch_bus.araddr : lsu_bus.araddr;
  assign out_bus.rready  = (grant_fetch && fetch_bus.rready) ||
                           (grant_lsu_rd && lsu_bus.rready);
  assign out_bus.awvalid = grant_lsu_wr && lsu_bus.awvalid;
  assign out_bus.awaddr  = lsu_bus.awaddr;
  assign out_bus.wvalid  = grant_lsu_wr && lsu_bus.wvalid;
  assign out_bus.wdata   = lsu_bus.wdata;
  assign out_bus.wstrb   = lsu_bus.wstrb;
  assign out_bus.bready  = grant_lsu_wr && lsu_bus.bready;

  // response goes back only to the granted manager
  assign fetch_bus.arready = grant_fetch && out_bus.arready;
  assign fetch_bus.rvalid  = grant_fetch && out_bus.rvalid;
  assign fetch_bus.rdata   = out_bus.rdata;
  assign fetch_bus.rresp   = out_bus.rresp;

  assign lsu_bus.arready = grant_lsu_rd && out_bus.arready;
  assign lsu_bus.rvalid  = grant_lsu_rd && out_bus.rvalid;
  assign lsu_bus.rdata   = out_bus.rdata;
  assign lsu_bus.rresp   = out_bus.rresp;
  assign lsu_bus.awready = grant_lsu_wr && out_bus.awready;
  assign lsu_bus.wready  = grant_lsu_wr && out_bus.wready;
  assign lsu_bus.bvalid  = grant_lsu_wr && out_bus.bvalid;
  assign lsu_bus.bresp   = out_bus.bresp;

  // a pending response means a held grant that does not move
  grant_held_a: assert property (@(posedge clock) disable iff (reset)
    ((out_bus.rvalid && !out_bus.rready) || (out_bus.bvalid && !out_bus.bready)) |=>
      (state != ARB_IDLE && $stable(state)));

endmodule

//--- rtl/addr_xbar.sv
`include "bus_cfg.svh"

module addr_xbar (
  input logic             clock,
  input logic             reset,
  axi_lite_if.subordinate in_bus,
  axi_lite_if.manager     ext_bus,
  axi_lite_if.manager     clint_bus
);
  import bus_pkg::*;

  route_e route_q;
  route_e route_dec;
  route_e route;
  logic   to_clint;
  logic   to_ext;
  logic   req_hs;
  logic   resp_hs;

  function automatic logic in_clint(input addr_t addr);
    return (addr & ~`CLINT_MASK) == `CLINT_BASE;
  endfunction

  always_comb begin
    route_dec = ROUTE_NONE;
    if (in_bus.arvalid) begin
      route_dec = in_clint(in_bus.araddr) ? ROUTE_CLINT_RD : ROUTE_EXT;
    end else if (in_bus.awvalid) begin
      route_dec = in_clint(in_bus.awaddr) ? ROUTE_CLINT_WR : ROUTE_EXT;
    end
  end

  // live decode until the request is taken, then the latched route
  assign route    = (route_q == ROUTE_NONE) ? route_dec : route_q;
  assign to_clint = (route == ROUTE_CLINT_RD) || (route == ROUTE_CLINT_WR);
  assign to_ext   = (route == ROUTE_EXT);

  assign req_hs  = (in_bus.arvalid && in_bus.arready) ||
                   (in_bus.awvalid && in_bus.awready);
  assign resp_hs = (in_bus.rvalid && in_bus.rready) ||
                   (in_bus.bvalid && in_bus.bready);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      route_q <= ROUTE_NONE;
    end else if (resp_hs) begin
      route_q <= ROUTE_NONE;
    end else if (req_hs) begin
      route_q <= route;
    end
  end

  assign ext_bus.awvalid = to_ext && in_bus.awvalid;
  assign ext_bus.awaddr  = in_bus.awaddr;
  assign ext_bus.wvalid  = to_ext && in_bus.wvalid;
  assign ext_bus.wdata   = in_bus.wdata;
  assign ext_bus.wstrb   = in_bus.wstrb;
  assign ext_bus.bready  = to_ext && in_bus.bready;
  assign ext_bus.arvalid = to_ext && in_bus.arvalid;
  assign ext_bus.araddr  = in_bus.araddr;
  assign ext_bus.rready  = to_ext && in_bus.rready;

  assign clint_bus.awvalid = to_clint && in_bus.awvalid;
  assign clint_bus.awaddr  = in_bus.awaddr;
  assign clint_bus.wvalid  = to_clint && in_bus.wvalid;
  assign clint_bus.wdata   = in_bus.wdata;
  assign clint_bus.wstrb   = in_bus.wstrb;
  assign clint_bus.bready  = to_clint && in_bus.bready;
  assign clint_bus.arvalid = to_clint && in_bus.arvalid;
  assign clint_bus.araddr  = in_bus.araddr;
  assign clint_bus.rready  = to_clint && in_bus.rready;

  // responses from the selected side only
  assign in_bus.awready = (to_ext && ext_bus.awready) || (to_clint && clint_bus.awready);
  assign in_bus.wready  = (to_ext && ext_bus.wready) || (to_clint && clint_bus.wready);
  assign in_bus.bvalid  = (to_ext && ext_bus.bvalid) || (to_clint && clint_bus.bvalid);
  assign in_bus.bresp   = to_clint ? clint_bus.bresp : ext_bus.bresp;
  assign in_bus.arready = (to_ext && ext_bus.arready) || (to_clint && clint_bus.arready);
  assign in_bus.rvalid  = (to_ext && ext_bus.rvalid) || (to_clint && clint_bus.rvalid);
  assign in_bus.rdata   = to_clint ? clint_bus.rdata : ext_bus.rdata;
  assign in_bus.rresp   = to_clint ? clint_bus.rresp : ext_bus.rresp;

  // a stalled response always has a latched route that does not move
  route_held_a: assert property (@(posedge clock) disable iff (reset)
    ((in_bus.rvalid && !in_bus.rready) || (in_bus.bvalid && !in_bus.bready)) |=>
      (route_q != ROUTE_NONE && $stable(route_q)));

endmodule

//--- rtl/clint_timer.sv
`include "bus_cfg.svh"

module clint_timer (
  input logic             clock,
  input logic             reset,
  axi_lite_if.subordinate bus
);
  import bus_pkg::*;

  logic [63:0] mtime;
  logic        rvalid_q;
  logic        bvalid_q;
  data_t       rdata_q;
  addr_t       rd_off;

  assign rd_off = bus.araddr & `CLINT_MASK;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (bus.arvalid && bus.arready) begin
        rvalid_q <= 1'b1;
      end else if (bus.rready) begin
        rvalid_q <= 1'b0;
      end
      // aw and w arrive together
      if (bus.awvalid && bus.awready && bus.wvalid && bus.wready) begin
        bvalid_q <= 1'b1;
      end else if (bus.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // sample mtime on the ar handshake
  always_ff @(posedge clock) begin
    if (bus.arvalid && bus.arready) begin
      case (rd_off)
        `MTIME_LO_OFF: rdata_q <= mtime[31:0];
        `MTIME_HI_OFF: rdata_q <= mtime[63:32];
        default:       rdata_q <= '0;
      endcase
    end
  end

  assign bus.arready = !rvalid_q;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = OKAY;

  // mtime is read-only, writes get an error
  assign bus.awready = !bvalid_q;
  assign bus.wready  = !bvalid_q;
  assign bus.bvalid  = bvalid_q;
  assign bus.bresp   = SLVERR;

  rdata_hold_a: assert property (@(posedge clock) disable iff (reset)
    (bus.rvalid && !bus.rready) |=> $stable(bus.rdata));

endmodule

//--- rtl/bus_fabric.sv
module bus_fabric (
  input  logic                clock,
  input  logic                reset,
  // fetch port, read only
  input  logic                fetch_arvalid_i,
  output logic                fetch_arready_o,
  input  bus_pkg::addr_t      fetch_araddr_i,
  output logic                fetch_rvalid_o,
  input  logic                fetch_rready_i,
  output bus_pkg::data_t      fetch_rdata_o,
  output bus_pkg::axi_resp_e  fetch_rresp_o,
  // load/store port
  input  logic                lsu_awvalid_i,
  output logic                lsu_awready_o,
  input  bus_pkg::addr_t      lsu_awaddr_i,
  input  logic                lsu_wvalid_i,
  output logic                lsu_wready_o,
  input  bus_pkg::data_t      lsu_wdata_i,
  input  bus_pkg::strb_t      lsu_wstrb_i,
  output logic                lsu_bvalid_o,
  input  logic                lsu_bready_i,
  output bus_pkg::axi_resp_e  lsu_bresp_o,
  input  logic                lsu_arvalid_i,
  output logic                lsu_arready_o,
  input  bus_pkg::addr_t      lsu_araddr_i,
  output logic                lsu_rvalid_o,
  input  logic                lsu_rready_i,
  output bus_pkg::data_t      lsu_rdata_o,
  output bus_pkg::axi_resp_e  lsu_rresp_o,
  // external manager port
  output logic                ext_awvalid_o,
  input  logic                ext_awready_i,
  output bus_pkg::addr_t      ext_awaddr_o,
  output logic                ext_wvalid_o,
  input  logic                ext_wready_i,
  output bus_pkg::data_t      ext_wdata_o,
  output bus_pkg::strb_t      ext_wstrb_o,
  input  logic                ext_bvalid_i,
  output logic                ext_bready_o,
  input  bus_pkg::axi_resp_e  ext_bresp_i,
  output logic                ext_arvalid_o,
  input  logic                ext_arready_i,
  output bus_pkg::addr_t      ext_araddr_o,
  input  logic                ext_rvalid_i,
  output logic                ext_rready_o,
  input  bus_pkg::data_t      ext_rdata_i,
  input  bus_pkg::axi_resp_e  ext_rresp_i
);

  axi_lite_if fetch_bus ();
  axi_lite_if lsu_bus ();
  axi_lite_if fabric_bus ();
  axi_lite_if ext_bus ();
  axi_lite_if clint_bus ();

  assign fetch_bus.arvalid = fetch_arvalid_i;
  assign fetch_bus.araddr  = fetch_araddr_i;
  assign fetch_bus.rready  = fetch_rready_i;
  assign fetch_arready_o   = fetch_bus.arready;
  assign fetch_rvalid_o    = fetch_bus.rvalid;
  assign fetch_rdata_o     = fetch_bus.rdata;
  assign fetch_rresp_o     = fetch_bus.rresp;

  assign lsu_bus.awvalid = lsu_awvalid_i;
  assign lsu_bus.awaddr  = lsu_awaddr_i;
  assign lsu_bus.wvalid  = lsu_wvalid_i;
  assign lsu_bus.wdata   = lsu_wdata_i;
  assign lsu_bus.wstrb   = lsu_wstrb_i;
  assign lsu_bus.bready  = lsu_bready_i;
  assign lsu_bus.arvalid = lsu_arvalid_i;
  assign lsu_bus.araddr  = lsu_araddr_i;
  assign lsu_bus.rready  = lsu_rready_i;
  assign lsu_awready_o   = lsu_bus.awready;
  assign lsu_wready_o    = lsu_bus.wready;
  assign lsu_bvalid_o    = lsu_bus.bvalid;
  assign lsu_bresp_o     = lsu_bus.bresp;
  assign lsu_arready_o   = lsu_bus.arready;
  assign lsu_rvalid_o    = lsu_bus.rvalid;
  assign lsu_rdata_o     = lsu_bus.rdata;
  assign lsu_rresp_o     = lsu_bus.rresp;

  assign ext_awvalid_o   = ext_bus.awvalid;
  assign ext_awaddr_o    = ext_bus.awaddr;
  assign ext_wvalid_o    = ext_bus.wvalid;
  assign ext_wdata_o     = ext_bus.wdata;
  assign ext_wstrb_o     = ext_bus.wstrb;
  assign ext_bready_o    = ext_bus.bready;
  assign ext_arvalid_o   = ext_bus.arvalid;
  assign ext_araddr_o    = ext_bus.araddr;
  assign ext_rready_o    = ext_bus.rready;
  assign ext_bus.awready = ext_awready_i;
  assign ext_bus.wready  = ext_wready_i;
  assign ext_bus.bvalid  = ext_bvalid_i;
  assign ext_bus.bresp   = ext_bresp_i;
  assign ext_bus.arready = ext_arready_i;
  assign ext_bus.rvalid  = ext_rvalid_i;
  assign ext_bus.rdata   = ext_rdata_i;
  assign ext_bus.rresp   = ext_rresp_i;

  bus_arbiter u_arbiter (
    .clock     (clock),
    .reset     (reset),
    .fetch_bus (fetch_bus),
    .lsu_bus   (lsu_bus),
    .out_bus   (fabric_bus)
  );

  addr_xbar u_xbar (
    .clock     (clock),
    .reset     (reset),
    .in_bus    (fabric_bus),
    .ext_bus   (ext_bus),
    .clint_bus (clint_bus)
  );

  clint_timer u_clint (
    .clock (clock),
    .reset (reset),
    .bus   (clint_bus)
  );

endmodule

//--- verification/bus_fabric_tb_tasks.svh
`ifndef BUS_FABRIC_TB_TASKS_SVH
`define BUS_FABRIC_TB_TASKS_SVH

task automatic check_data(input data_t got, input data_t exp, input string what);
  if (got !== exp) begin
    check_errors++;
    $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_addr(input addr_t got, input addr_t exp, input string what);
  if (got !== exp) begin
    check_errors++;
    $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_strb(input strb_t got, input strb_t exp, input string what);
  if (got !== exp) begin
    check_errors++;
    $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
  if (got !== exp) begin
    check_errors++;
    $display("CHECK FAILED at %0t: %s, got %s, expected %s", $time, what, got.name(),
             exp.name());
  end
endtask

task automatic idle_cycles(input int n);
  repeat (n) begin
    @(posedge clock);
    #2;
  end
endtask

function automatic int pick_delay();
  return $unsigned($random(seed)) % 4;
endfunction

// every bus task starts and ends just after a rising edge
task automatic fetch_ar(input addr_t addr, output int hs_cycle);
  int n;
  n = 0;
  fetch_arvalid_i = 1'b1;
  fetch_araddr_i  = addr;
  @(negedge clock);
  while (!fetch_arready_o && n < HS_LIMIT) begin
    n++;
    @(negedge clock);
  end
  if (!fetch_arready_o) begin
    hs_errors++;
    $display("fetch read of %h was never accepted", addr);
  end
  hs_cycle = cycle_cnt;
  @(posedge clock);
  #2;
  fetch_arvalid_i = 1'b0;
endtask

task automatic fetch_r(output data_t data, output axi_resp_e resp);
  int n;
  n = 0;
  @(negedge clock);
  while (!fetch_rvalid_o && n < HS_LIMIT) begin
    n++;
    @(negedge clock);
  end
  if (!fetch_rvalid_o) begin
    hs_errors++;
    $display("fetch read response never arrived");
  end
  data = fetch_rdata_o;
  resp = fetch_rresp_o;
  @(posedge clock);
  #2;
endtask

task automatic fetch_read(input addr_t addr, output data_t data, output axi_resp_e resp,
                          output int hs_cycle);
  fetch_ar(addr, hs_cycle);
  fetch_r(data, resp);
endtask

task automatic lsu_read(input addr_t addr, output data_t data, output axi_resp_e resp,
                        output int hs_cycle);
  int n;
  n = 0;
  lsu_arvalid_i = 1'b1;
  lsu_araddr_i  = addr;
  @(negedge clock);
  while (!lsu_arready_o && n < HS_LIMIT) begin
    n++;
    @(negedge clock);
  end
  if (!lsu_arready_o) begin
    hs_errors++;
    $display("load/store read of %h was never accepted", addr);
  end
  hs_cycle = cycle_cnt;
  @(posedge clock);
  #2;
  lsu_arvalid_i = 1'b0;
  n = 0;
  @(negedge clock);
  while (!lsu_rvalid_o && n < HS_LIMIT) begin
    n++;
    @(negedge clock);
  end
  if (!lsu_rvalid_o) begin
    hs_errors++;
    $display("load/store read response for %h never arrived", addr);
  end
  data = lsu_rdata_o;
  resp = lsu_rresp_o;
  @(posedge clock);
  #2;
endtask

task automatic lsu_write(input addr_t addr, input data_t data, input strb_t strb,
                         output axi_resp_e resp);
  int n;
  n = 0;
  lsu_awvalid_i = 1'b1;
  lsu_awaddr_i  = addr;
  lsu_wvalid_i  = 1'b1;
  lsu_wdata_i   = data;
  lsu_wstrb_i   = strb;
  @(negedge clock);
  while (!(lsu_awready_o && lsu_wready_o) && n < HS_LIMIT) begin
    n++;
    @(negedge clock);
  end
  if (!(lsu_awready_o && lsu_wready_o)) begin
    hs_errors++;
    $display("load/store write to %h was never accepted", addr);
  end
  @(posedge clock);
  #2;
  lsu_awvalid_i = 1'b0;
  lsu_wvalid_i  = 1'b0;
  n = 0;
  @(negedge clock);
  while (!lsu_bvalid_o && n < HS_LIMIT) begin
    n++;
    @(negedge clock);
  end
  if (!lsu_bvalid_o) begin
    hs_errors++;
    $display("load/store write response for %h never arrived", addr);
  end
  resp = lsu_bresp_o;
  @(posedge clock);
  #2;
endtask

`endif

//--- verification/bus_fabric_tb.sv
`include "bus_cfg.svh"

module bus_fabric_tb;
  import bus_pkg::*;

  localparam int RESET_CYCLES    = 8;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 332;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST;
  localparam int HS_LIMIT        = 40;

  localparam addr_t MTIME_LO = `CLINT_BASE | `MTIME_LO_OFF;
  localparam addr_t MTIME_HI = `CLINT_BASE | `MTIME_HI_OFF;
  localparam addr_t EXT_A    = 32'h8000_0100;
  localparam addr_t EXT_B    = 32'h8000_2344;
  localparam addr_t EXT_C    = 32'h9000_0f00;
  localparam data_t RD_XOR   = 32'h5a5a_5a5a;

  logic clock = 1'b0;
  logic reset;

  logic fetch_arvalid_i, fetch_arready_o, fetch_rvalid_o, fetch_rready_i;
  addr_t fetch_araddr_i;
  data_t fetch_rdata_o;
  axi_resp_e fetch_rresp_o;

  logic lsu_awvalid_i, lsu_awready_o, lsu_wvalid_i, lsu_wready_o;
  logic lsu_bvalid_o, lsu_bready_i, lsu_arvalid_i, lsu_arready_o;
  logic lsu_rvalid_o, lsu_rready_i;
  addr_t lsu_awaddr_i, lsu_araddr_i;
  data_t lsu_wdata_i, lsu_rdata_o;
  strb_t lsu_wstrb_i;
  axi_resp_e lsu_bresp_o, lsu_rresp_o;

  logic ext_awvalid_o, ext_awready_i, ext_wvalid_o, ext_wready_i;
  logic ext_bvalid_i, ext_bready_o, ext_arvalid_o, ext_arready_i;
  logic ext_rvalid_i, ext_rready_o;
  addr_t ext_awaddr_o, ext_araddr_o;
  data_t ext_wdata_o, ext_rdata_i;
  strb_t ext_wstrb_o;
  axi_resp_e ext_bresp_i, ext_rresp_i;

  integer seed = 32'h93c7_c07b;
  int cycle_cnt = 0;
  int check_errors = 0;
  int hs_errors = 0;

  // seen by the external subordinate
  addr_t ar_log[$];
  addr_t last_awaddr;
  data_t last_wdata;
  strb_t last_wstrb;

  bus_fabric UUT (.*);

  always #20 clock = ~clock;

  always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

  `include "bus_fabric_tb_tasks.svh"

  // external subordinate, one transaction at a time
  initial begin : ext_model
    addr_t addr;
    ext_awready_i = 1'b0;
    ext_wready_i  = 1'b0;
    ext_bvalid_i  = 1'b0;
    ext_bresp_i   = OKAY;
    ext_arready_i = 1'b0;
    ext_rvalid_i  = 1'b0;
    ext_rdata_i   = '0;
    ext_rresp_i   = OKAY;
    forever begin
      @(negedge clock);
      if (ext_arvalid_o) begin
        idle_cycles(1 + pick_delay());
        addr = ext_araddr_o;
        ar_log.push_back(addr);
        ext_arready_i = 1'b1;
        idle_cycles(1);
        ext_arready_i = 1'b0;
        idle_cycles(pick_delay());
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = addr ^ RD_XOR;
        ext_rresp_i  = OKAY;
        @(negedge clock);
        while (!ext_rready_o) @(negedge clock);
        idle_cycles(1);
        ext_rvalid_i = 1'b0;
      end else if (ext_awvalid_o && ext_wvalid_o) begin
        idle_cycles(1 + pick_delay());
        last_awaddr   = ext_awaddr_o;
        last_wdata    = ext_wdata_o;
        last_wstrb    = ext_wstrb_o;
        ext_awready_i = 1'b1;
        ext_wready_i  = 1'b1;
        idle_cycles(1);
        ext_awready_i = 1'b0;
        ext_wready_i  = 1'b0;
        idle_cycles(pick_delay());
        ext_bvalid_i = 1'b1;
        ext_bresp_i  = OKAY;
        @(negedge clock);
        while (!ext_bready_o) @(negedge clock);
        idle_cycles(1);
        ext_bvalid_i = 1'b0;
      end
    end
  end

  task automatic fetch_reads_ext();
    data_t data;
    axi_resp_e resp;
    int cyc;
    fetch_read(EXT_A, data, resp, cyc);
    check_addr(ar_log[$], EXT_A, "fetch address on ext port");
    check_data(data, EXT_A ^ RD_XOR, "fetch read data");
    check_resp(resp, OKAY, "fetch read resp");
  endtask

  task automatic lsu_writes_ext();
    data_t wdata;
    axi_resp_e resp;
    wdata = $random(seed);
    lsu_write(EXT_B, wdata, 4'b0110, resp);
    check_addr(last_awaddr, EXT_B, "write address at ext port");
    check_data(last_wdata, wdata, "write data at ext port");
    check_strb(last_wstrb, 4'b0110, "write strobes at ext port");
    check_resp(resp, OKAY, "write resp");
  endtask

  task automatic lsu_wins_read_tie();
    data_t fdata;
    data_t ldata;
    axi_resp_e fresp;
    axi_resp_e lresp;
    int fcyc;
    int lcyc;
    int base;
    base = ar_log.size();
    fork
      fetch_read(EXT_A, fdata, fresp, fcyc);
      lsu_read(EXT_C, ldata, lresp, lcyc);
    join
    if (ar_log.size() != base + 2) begin
      check_errors++;
      $display("CHECK FAILED at %0t: expected two reads at the ext port, saw %0d", $time,
               ar_log.size() - base);
    end else begin
      check_addr(ar_log[base], EXT_C, "first ext read is load/store");
      check_addr(ar_log[base + 1], EXT_A, "second ext read is fetch");
    end
    check_data(ldata, EXT_C ^ RD_XOR, "load/store data under contention");
    check_data(fdata, EXT_A ^ RD_XOR, "fetch data under contention");
  endtask

  task automatic mtime_counts_cycles();
    data_t first;
    data_t second;
    data_t high;
    axi_resp_e resp;
    int c1;
    int c2;
    int c3;
    lsu_read(MTIME_LO, first, resp, c1);
    check_resp(resp, OKAY, "mtime low resp");
    idle_cycles(3);
    fetch_read(MTIME_LO, second, resp, c2);
    check_data(second - first, data_t'(c2 - c1), "mtime advance between reads");
    lsu_read(MTIME_HI, high, resp, c3);
    check_data(high, '0, "mtime high word");
  endtask

  task automatic clint_refuses_write();
    axi_resp_e resp;
    logic done;
    logic aw_seen;
    done    = 1'b0;
    aw_seen = 1'b0;
    fork
      begin
        lsu_write(MTIME_LO, 32'hdead_beef, 4'hf, resp);
        done = 1'b1;
      end
      begin
        while (!done) begin
          @(negedge clock);
          if (ext_awvalid_o) aw_seen = 1'b1;
        end
      end
    join
    idle_cycles(1);
    check_resp(resp, SLVERR, "CLINT write resp");
    if (aw_seen) begin
      check_errors++;
      $display("ext_awvalid went high during a write into the CLINT window");
    end
  endtask

  task automatic fetch_response_held();
    data_t held;
    data_t data;
    axi_resp_e resp;
    int cyc;
    fetch_rready_i = 1'b0;
    fetch_ar(MTIME_LO, cyc);
    @(negedge clock);
    held = fetch_rdata_o;
    if (!fetch_rvalid_o) begin
      check_errors++;
      $display("fetch rvalid did not rise one cycle after the CLINT read");
    end
    @(posedge clock);
    #2;
    lsu_arvalid_i = 1'b1;
    lsu_araddr_i  = EXT_A;
    repeat (5) begin
      @(negedge clock);
      if (!fetch_rvalid_o) begin
        check_errors++;
        $display("fetch rvalid dropped while rready was low");
      end
      check_data(fetch_rdata_o, held, "held fetch rdata");
      if (ext_arvalid_o) begin
        check_errors++;
        $display("load/store read was forwarded while the fetch response was pending");
      end
    end
    @(posedge clock);
    #2;
    fetch_rready_i = 1'b1;
    fetch_r(data, resp);
    check_data(data, held, "fetch rdata once accepted");
    lsu_read(EXT_A, data, resp, cyc);
    check_data(data, EXT_A ^ RD_XOR, "load/store read after back-pressure");
  endtask

  initial begin : main
    fetch_arvalid_i = 1'b0;
    fetch_araddr_i  = '0;
    fetch_rready_i  = 1'b1;
    lsu_awvalid_i   = 1'b0;
    lsu_awaddr_i    = '0;
    lsu_wvalid_i    = 1'b0;
    lsu_wdata_i     = '0;
    lsu_wstrb_i     = '0;
    lsu_bready_i    = 1'b1;
    lsu_arvalid_i   = 1'b0;
    lsu_araddr_i    = '0;
    lsu_rready_i    = 1'b1;
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b0;
    fetch_reads_ext();
    lsu_writes_ext();
    lsu_wins_read_tie();
    mtime_counts_cycles();
    clint_refuses_write();
    fetch_response_held();
    $display("errors: %0d check, %0d handshake", check_errors, hs_errors);
    if (check_errors == 0 && hs_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("run did not finish within %0d cycles, a handshake is stuck", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

//--- bus_fabric.f
+incdir+rtl
+incdir+verification
rtl/bus_pkg.sv
rtl/axi_lite_if.sv
rtl/bus_arbiter.sv
rtl/addr_xbar.sv
rtl/clint_timer.sv
rtl/bus_fabric.sv
verification/bus_fabric_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f bus_fabric.f --top-module bus_fabric_tb -o bus_fabric_sim
./obj_dir/bus_fabric_sim > sim.log 2>&1
cat sim.log
if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation passed"
